// File: src.f
design/player_pkg.sv
design/display_pkg.sv
design/kbd_command.sv
design/rate_control.sv
design/flash_reader.sv
design/display_latch.sv
design/seg_digit.sv
design/ipod_top.sv
testbench/tb_checker.sv
testbench/tb_ipod.sv

// File: Makefile
# Verilator build and run for the flash sample player

TOP       ?= tb_ipod
FILELIST  ?= src.f
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_TEXT ?= No errors

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Fails unless the pass line shows up in the simulation output
run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_ipod.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ipod;

  import player_pkg::*;
  import display_pkg::*;

  localparam div_count_t  DEFAULT_DIV    = 16'd8;
  localparam div_count_t  MIN_DIV        = 16'd4;
  localparam div_count_t  MAX_DIV        = 16'd16;
  localparam div_count_t  DIV_STEP       = 16'd2;
  localparam flash_addr_t LAST_WORD      = 23'd7;
  localparam int          REFRESH_CYCLES = 16;

  localparam int NUM_STEPS = 18;
  localparam int MARGIN    = 200;

  localparam logic [1:0] K_ASCII = 2'd1;
  localparam logic [1:0] K_KEY   = 2'd2;

  // One table row, key code 0 up, 1 down, 2 rate reset
  typedef struct packed {
    logic [1:0]  kind;
    logic [7:0]  code;
    logic [15:0] hold;
    logic [15:0] exp_div;
    logic        fast;
  } step_t;

  step_t       steps [NUM_STEPS];
  logic        CLK_50M;
  logic        arst_n;
  logic [7:0]  kbd_ascii;
  logic        kbd_valid;
  logic [2:0]  key_n;
  logic        flash_read;
  flash_addr_t flash_address;
  logic        flash_waitrequest;
  flash_word_u flash_readdata;
  logic        flash_readdatavalid;
  sample_t     audio_sample;
  logic        sample_valid;
  seg_bank_t   segs;
  logic        fast_flash;
  logic [15:0] exp_div;
  logic        exp_check;
  int          value_errs;
  int          protocol_errs;
  int          cycle_count;
  int          cycle_limit;
  logic [7:0]  lfsr_state;

  // Flash model state
  logic        rd_q;
  logic        wait_q;
  flash_addr_t addr_q;
  logic        fast_q;
  logic        req_seen;
  int          wait_left;
  logic        data_pending;
  int          data_wait;
  flash_addr_t data_addr;

  ipod_top #(
    .DEFAULT_DIV    (DEFAULT_DIV),
    .MIN_DIV        (MIN_DIV),
    .MAX_DIV        (MAX_DIV),
    .DIV_STEP       (DIV_STEP),
    .LAST_WORD      (LAST_WORD),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) dut0 (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .kbd_ascii           (kbd_ascii),
    .kbd_valid           (kbd_valid),
    .key_n               (key_n),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_valid        (sample_valid),
    .segs                (segs)
  );

  tb_checker #(
    .DEFAULT_DIV (DEFAULT_DIV),
    .MIN_DIV     (MIN_DIV),
    .MAX_DIV     (MAX_DIV),
    .DIV_STEP    (DIV_STEP),
    .LAST_WORD   (LAST_WORD)
  ) checker0 (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .kbd_ascii           (kbd_ascii),
    .kbd_valid           (kbd_valid),
    .key_n               (key_n),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_valid        (sample_valid),
    .segs                (segs),
    .fast_flash          (fast_flash),
    .exp_div             (exp_div),
    .exp_check           (exp_check),
    .value_errs          (value_errs),
    .protocol_errs       (protocol_errs)
  );

  initial
    CLK_50M = 1'b0;

  always #10 CLK_50M = ~CLK_50M;

  function automatic step_t make_step(input logic [1:0] kind, input logic [7:0] code,
                                      input logic [15:0] hold, input logic [15:0] div,
                                      input logic fast);
    step_t s;
    s.kind    = kind;
    s.code    = code;
    s.hold    = hold;
    s.exp_div = div;
    s.fast    = fast;
    return s;
  endfunction

  // Fibonacci LFSR, x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb         = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
    lfsr_state = {lfsr_state[6:0], fb};
    return fb;
  endfunction

  // 0 to 3 cycles, none when fast responses are asked for
  function automatic int draw_delay(input logic fast);
    logic b0;
    logic b1;
    if (fast)
      return 0;
    b0 = lfsr_bit();
    b1 = lfsr_bit();
    return int'({b1, b0});
  endfunction

  function automatic logic [31:0] word_at(input flash_addr_t a);
    logic [24:0] p;
    logic [24:0] v;
    logic [31:0] w;
    for (int i = 0; i < 4; i++)
    begin
      p = {a, 2'(i)};
      v = p * 25'd7 + 25'd3;
      w[i*8 +: 8] = v[7:0];
    end
    return w;
  endfunction

  // ====================
  // Flash memory model
  // ====================
  always @(posedge CLK_50M)
  begin
    rd_q   = flash_read;
    wait_q = flash_waitrequest;
    addr_q = flash_address;
    fast_q = fast_flash;
    #2;
    flash_readdatavalid = 1'b0;
    if (!arst_n)
    begin
      req_seen          = 1'b0;
      data_pending      = 1'b0;
      flash_waitrequest = 1'b0;
    end
    else
    begin
      if (rd_q && !wait_q)
      begin
        req_seen     = 1'b0;
        data_pending = 1'b1;
        data_addr    = addr_q;
        data_wait    = draw_delay(fast_q);
      end
      if (data_pending)
      begin
        if (data_wait == 0)
        begin
          flash_readdatavalid = 1'b1;
          flash_readdata.raw  = word_at(data_addr);
          data_pending        = 1'b0;
        end
        else
          data_wait = data_wait - 1;
      end
      if (flash_read && !req_seen)
      begin
        req_seen  = 1'b1;
        wait_left = draw_delay(fast_q);
      end
      flash_waitrequest = req_seen && (wait_left > 0);
      if (req_seen && wait_left > 0)
        wait_left = wait_left - 1;
    end
  end

  task automatic apply_step(input step_t s);
    @(posedge CLK_50M);
    #2;
    exp_check  = 1'b0;
    fast_flash = s.fast;
    exp_div    = s.exp_div;
    if (s.kind == K_ASCII)
    begin
      kbd_ascii = s.code;
      kbd_valid = 1'b1;
    end
    else if (s.kind == K_KEY)
      key_n[s.code[1:0]] = 1'b0;
    for (int n = 1; n < int'(s.hold); n++)
    begin
      @(posedge CLK_50M);
      #2;
      kbd_valid = 1'b0;
      if (n == 3)
        key_n = '1;
      exp_check = (n == int'(s.hold) - 1);
    end
  endtask

  // Run limit
  always @(posedge CLK_50M)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  initial
  begin
    arst_n              = 1'b1;
    kbd_ascii           = 8'h00;
    kbd_valid           = 1'b0;
    key_n               = '1;
    flash_waitrequest   = 1'b0;
    flash_readdata.raw  = '0;
    flash_readdatavalid = 1'b0;
    fast_flash          = 1'b0;
    exp_div             = DEFAULT_DIV;
    exp_check           = 1'b0;
    cycle_count         = 0;
    lfsr_state          = 8'd73;
    req_seen            = 1'b0;
    wait_left           = 0;
    data_pending        = 1'b0;
    data_wait           = 0;
    data_addr           = '0;

    // Forward play under random flash delays, then rate keys
    steps[0]  = make_step(K_ASCII, "E", 16'd400, 16'd8, 1'b0);
    steps[1]  = make_step(K_KEY, 8'd1, 16'd30, 16'd10, 1'b1);
    steps[2]  = make_step(K_KEY, 8'd1, 16'd30, 16'd12, 1'b1);
    steps[3]  = make_step(K_KEY, 8'd1, 16'd30, 16'd14, 1'b1);
    steps[4]  = make_step(K_KEY, 8'd1, 16'd30, 16'd16, 1'b1);
    steps[5]  = make_step(K_KEY, 8'd1, 16'd30, 16'd16, 1'b1);
    steps[6]  = make_step(K_ASCII, "D", 16'd40, 16'd16, 1'b1);
    steps[7]  = make_step(K_KEY, 8'd2, 16'd30, 16'd8, 1'b1);
    steps[8]  = make_step(K_KEY, 8'd0, 16'd30, 16'd6, 1'b1);
    steps[9]  = make_step(K_KEY, 8'd0, 16'd30, 16'd4, 1'b1);
    steps[10] = make_step(K_KEY, 8'd0, 16'd30, 16'd4, 1'b1);
    // Backward play, restart, then forward again
    steps[11] = make_step(K_ASCII, "B", 16'd20, 16'd4, 1'b1);
    steps[12] = make_step(K_ASCII, "E", 16'd300, 16'd4, 1'b1);
    steps[13] = make_step(K_ASCII, "R", 16'd60, 16'd4, 1'b0);
    steps[14] = make_step(K_KEY, 8'd2, 16'd40, 16'd8, 1'b0);
    steps[15] = make_step(K_ASCII, "F", 16'd200, 16'd8, 1'b0);
    steps[16] = make_step(K_ASCII, "D", 16'd40, 16'd8, 1'b0);
    steps[17] = make_step(K_ASCII, "X", 16'd20, 16'd8, 1'b0);

    cycle_limit = MARGIN;
    for (int i = 0; i < NUM_STEPS; i++)
      cycle_limit = cycle_limit + int'(steps[i].hold);

    // Reset goes low before the first clock edge
    #1;
    arst_n = 1'b0;
    repeat (2) @(posedge CLK_50M);
    #2;
    arst_n = 1'b1;

    for (int i = 0; i < NUM_STEPS; i++)
      apply_step(steps[i]);

    @(posedge CLK_50M);
    #2;
    exp_check = 1'b0;
    repeat (2) @(posedge CLK_50M);

    $display("Checks done with %0d value errors and %0d protocol errors",
             value_errs, protocol_errs);
    if (value_errs == 0 && protocol_errs == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
  parameter player_pkg::div_count_t  DEFAULT_DIV = 16'd8,
  parameter player_pkg::div_count_t  MIN_DIV     = 16'd4,
  parameter player_pkg::div_count_t  MAX_DIV     = 16'd16,
  parameter player_pkg::div_count_t  DIV_STEP    = 16'd2,
  parameter player_pkg::flash_addr_t LAST_WORD   = 23'd7
) (
  input  wire logic                   CLK_50M,
  input  wire logic                   arst_n,
  input  wire logic [7:0]             kbd_ascii,
  input  wire logic                   kbd_valid,
  input  wire logic [2:0]             key_n,
  input  wire logic                   flash_read,
  input  wire player_pkg::flash_addr_t flash_address,
  input  wire logic                   flash_waitrequest,
  input  wire logic                   flash_readdatavalid,
  input  wire player_pkg::sample_t    audio_sample,
  input  wire logic                   sample_valid,
  input  wire display_pkg::seg_bank_t segs,
  input  wire logic                   fast_flash,
  input  wire logic [15:0]            exp_div,
  input  wire logic                   exp_check,
  output int                          value_errs,
  output int                          protocol_errs
);

  import player_pkg::*;
  import display_pkg::*;

  localparam logic [24:0] LAST_POS = {LAST_WORD, 2'b11};
  // Key sample to visible segments: 4 cycles of sync, one refresh, margin
  localparam int SHOW_DELAY = 22;

  logic [24:0] pos;
  logic        playing;
  logic        backward;
  logic        restart_pending;
  div_count_t  div_model;
  logic [2:0]  key_prev;
  logic [2:0]  press;
  logic        rd_prev;
  logic        wr_prev;
  flash_addr_t addr_prev;
  logic        rd_busy;
  logic        have_prev;
  logic [7:0]  exp_byte;
  int          since_change;
  int          stop_age;
  int          gap;
  int          fast_age;

  function automatic logic [7:0] byte_at(input logic [24:0] p);
    logic [24:0] v;
    v = p * 25'd7 + 25'd3;
    return v[7:0];
  endfunction

  // Segments lit, g down to a, then inverted
  function automatic seg_t seg_of(input hex_digit_t d);
    logic [6:0] lit;
    case (d)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  function automatic seg_bank_t bank_of(input div_count_t d);
    logic [23:0] v;
    logic [41:0] b;
    v = {8'h00, d};
    for (int i = 0; i < NUM_DIGITS; i++)
      b[i*7 +: 7] = seg_of(v[i*4 +: 4]);
    return b;
  endfunction

  always @(posedge CLK_50M)
  begin
    if (!arst_n)
    begin
      if (flash_read || sample_valid)
      begin
        $display("Flash read or sample valid went high during reset");
        protocol_errs = protocol_errs + 1;
      end
      if (segs !== bank_of(DEFAULT_DIV))
      begin
        $display("Fail segs expected %h got %h", bank_of(DEFAULT_DIV), segs);
        value_errs = value_errs + 1;
      end
      pos             = '0;
      playing         = 1'b0;
      backward        = 1'b0;
      restart_pending = 1'b0;
      div_model       = DEFAULT_DIV;
      key_prev        = '1;
      rd_busy         = 1'b0;
      have_prev       = 1'b0;
      since_change    = SHOW_DELAY;
      stop_age        = 100;
      gap             = 0;
      fast_age        = 0;
    end
    else
    begin
      // ====================
      // Flash port rules
      // ====================
      if (rd_prev && wr_prev && (!flash_read || flash_address != addr_prev))
      begin
        $display("Flash request dropped or moved while waitrequest was high");
        protocol_errs = protocol_errs + 1;
      end
      if (flash_address > LAST_WORD)
      begin
        $display("Fail flash_address expected <= %h got %h", LAST_WORD, flash_address);
        value_errs = value_errs + 1;
      end
      // Only the returned word may produce a sample, and only once it is back
      if (sample_valid && rd_busy)
      begin
        $display("A sample came out while a flash read was still outstanding");
        protocol_errs = protocol_errs + 1;
      end
      if (flash_read && rd_busy)
      begin
        $display("A second flash read started before the first one returned");
        protocol_errs = protocol_errs + 1;
      end
      if (flash_readdatavalid)
        rd_busy = 1'b0;
      if (flash_read && !flash_waitrequest)
        rd_busy = 1'b1;

      // ====================
      // Sample stream
      // ====================
      if (!playing && stop_age < 100)
        stop_age = stop_age + 1;
      if (sample_valid)
      begin
        if (!playing && stop_age >= 2)
        begin
          $display("A sample came out after playback was stopped");
          protocol_errs = protocol_errs + 1;
        end
        exp_byte = byte_at(pos);
        if (audio_sample !== sample_t'(exp_byte))
        begin
          $display("Fail audio_sample expected %h got %h", exp_byte, audio_sample);
          value_errs = value_errs + 1;
        end
        // A word miss costs two cycles more than a hit
        if (fast_age >= 20 && have_prev && since_change >= 40 &&
            gap + 1 < int'(div_model) - 2)
        begin
          $display("Samples came closer together than the divider allows");
          protocol_errs = protocol_errs + 1;
        end
        have_prev = 1'b1;
        gap       = 0;
        if (backward)
          pos = (pos == '0) ? LAST_POS : pos - 1'b1;
        else
          pos = (pos == LAST_POS) ? '0 : pos + 1'b1;
      end
      else
        gap = gap + 1;

      // Restart lands one cycle after the command is taken
      if (restart_pending)
      begin
        pos             = backward ? LAST_POS : '0;
        restart_pending = 1'b0;
      end
      if (kbd_valid)
      begin
        have_prev = 1'b0;
        case (kbd_ascii)
          8'h45: playing = 1'b1;
          8'h44:
          begin
            playing  = 1'b0;
            stop_age = 0;
          end
          8'h46:
          begin
            backward        = 1'b0;
            restart_pending = 1'b1;
          end
          8'h42:
          begin
            backward        = 1'b1;
            restart_pending = 1'b1;
          end
          8'h52: restart_pending = 1'b1;
          default: ;
        endcase
      end

      // ====================
      // Divider and display
      // ====================
      press    = key_prev & ~key_n;
      key_prev = key_n;
      if (press[2])
        div_model = DEFAULT_DIV;
      else if (press[0])
        div_model = (div_model >= MIN_DIV + DIV_STEP) ? div_model - DIV_STEP : MIN_DIV;
      else if (press[1])
        div_model = (div_model + DIV_STEP <= MAX_DIV) ? div_model + DIV_STEP : MAX_DIV;
      if (press != 3'b000)
        since_change = 0;
      else if (since_change < 1000)
        since_change = since_change + 1;

      if (fast_flash)
        fast_age = (fast_age < 1000) ? fast_age + 1 : fast_age;
      else
        fast_age = 0;

      if (since_change >= SHOW_DELAY && segs !== bank_of(div_model))
      begin
        $display("Fail segs expected %h got %h", bank_of(div_model), segs);
        value_errs = value_errs + 1;
      end
      // Divider count from the table, as the display shows it
      if (exp_check && segs !== bank_of(exp_div))
      begin
        $display("Fail segs expected %h got %h", bank_of(exp_div), segs);
        value_errs = value_errs + 1;
      end
    end
    rd_prev   = flash_read;
    wr_prev   = flash_waitrequest;
    addr_prev = flash_address;
  end

endmodule

`default_nettype wire

// File: design/ipod_top.sv
`timescale 1ns/1ps
`default_nettype none

module ipod_top #(
  parameter player_pkg::div_count_t  DEFAULT_DIV    = 16'd2268,
  parameter player_pkg::div_count_t  MIN_DIV        = 16'd568,
  parameter player_pkg::div_count_t  MAX_DIV        = 16'd9072,
  parameter player_pkg::div_count_t  DIV_STEP       = 16'd64,
  parameter player_pkg::flash_addr_t LAST_WORD      = 23'h7FFFF,
  parameter int unsigned             REFRESH_CYCLES = 25_000_000
) (
  input  wire logic                    CLK_50M,
  input  wire logic                    arst_n,
  input  wire player_pkg::sample_t     kbd_ascii,
  input  wire logic                    kbd_valid,
  input  wire logic [2:0]              key_n,
  output logic                         flash_read,
  output player_pkg::flash_addr_t      flash_address,
  input  wire logic                    flash_waitrequest,
  input  wire player_pkg::flash_word_u flash_readdata,
  input  wire logic                    flash_readdatavalid,
  output player_pkg::sample_t          audio_sample,
  output logic                         sample_valid,
  output display_pkg::seg_bank_t       segs
);

  import player_pkg::*;
  import display_pkg::*;

  play_ctrl_t                   play_ctrl;
  logic                         sample_tick;
  div_count_t                   div_count;
  hex_digit_t [NUM_DIGITS-1:0]  digits;
  seg_t [NUM_DIGITS-1:0]        seg_array;

  // ====================
  // Playback path
  // ====================
  kbd_command kbd_command0 (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .kbd_ascii (kbd_ascii),
    .kbd_valid (kbd_valid),
    .play_ctrl (play_ctrl)
  );

  rate_control #(
    .DEFAULT_DIV (DEFAULT_DIV),
    .MIN_DIV     (MIN_DIV),
    .MAX_DIV     (MAX_DIV),
    .DIV_STEP    (DIV_STEP)
  ) rate_control0 (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .key_n       (key_n),
    .playing     (play_ctrl.playing),
    .div_count   (div_count),
    .sample_tick (sample_tick)
  );

  flash_reader #(
    .LAST_WORD (LAST_WORD)
  ) flash_reader0 (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .play_ctrl           (play_ctrl),
    .sample_tick         (sample_tick),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_valid        (sample_valid)
  );

  // ====================
  // Divider count display
  // ====================
  display_latch #(
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) display_latch0 (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .div_count (div_count),
    .digits    (digits)
  );

  for (genvar i = 0; i < NUM_DIGITS; i++)
  begin : g_digit
    seg_digit seg_digit0 (
      .digit (digits[i]),
      .seg   (seg_array[i])
    );
  end

  // Digit 5 lands in hex5
  assign segs = seg_array;

endmodule

`default_nettype wire

// File: design/seg_digit.sv
`timescale 1ns/1ps
`default_nettype none

module seg_digit (
  input  wire display_pkg::hex_digit_t digit,
  output display_pkg::seg_t            seg
);

  // Patterns read g down to a, a zero lights the segment
  always_comb
  begin
    case (digit)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'hA: seg = 7'b0001000;
      4'hB: seg = 7'b0000011;
      4'hC: seg = 7'b1000110;
      4'hD: seg = 7'b0100001;
      4'hE: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
  end

endmodule

`default_nettype wire

// File: design/display_latch.sv
`timescale 1ns/1ps
`default_nettype none

module display_latch #(
  parameter int unsigned REFRESH_CYCLES = 25_000_000
) (
  input  wire logic                                             CLK_50M,
  input  wire logic                                             arst_n,
  input  wire player_pkg::div_count_t                           div_count,
  output display_pkg::hex_digit_t [display_pkg::NUM_DIGITS-1:0] digits
);

  import display_pkg::*;

  localparam int DISP_W = $bits(hex_digit_t) * NUM_DIGITS;
  localparam int CNT_W  = $clog2(REFRESH_CYCLES + 1);

  logic [CNT_W-1:0]  refresh_cnt;
  logic              shown_valid;
  logic [DISP_W-1:0] shown;
  logic [DISP_W-1:0] live;

  assign live = DISP_W'(div_count);

  // Refresh interval and capture flag
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      refresh_cnt <= '0;
      shown_valid <= 1'b0;
    end
    else if (refresh_cnt == CNT_W'(REFRESH_CYCLES - 1))
    begin
      refresh_cnt <= '0;
      shown_valid <= 1'b1;
    end
    else
      refresh_cnt <= refresh_cnt + 1'b1;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (refresh_cnt == CNT_W'(REFRESH_CYCLES - 1))
      shown <= live;
  end

  // Live count until the first capture, so the reset value shows at once
  assign digits = shown_valid ? shown : live;

endmodule

`default_nettype wire

// File: design/flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module flash_reader #(
  parameter player_pkg::flash_addr_t LAST_WORD = 23'h7FFFF
) (
  input  wire logic                    CLK_50M,
  input  wire logic                    arst_n,
  input  wire player_pkg::play_ctrl_t  play_ctrl,
  input  wire logic                    sample_tick,
  output logic                         flash_read,
  output player_pkg::flash_addr_t      flash_address,
  input  wire logic                    flash_waitrequest,
  input  wire player_pkg::flash_word_u flash_readdata,
  input  wire logic                    flash_readdatavalid,
  output player_pkg::sample_t          audio_sample,
  output logic                         sample_valid
);

  import player_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_WAIT
  } state_t;

  // Position is word address times four plus lane
  localparam logic [24:0] LAST_POS = {LAST_WORD, 2'b11};

  state_t      state;
  logic [24:0] pos;
  logic [24:0] next_pos;
  flash_addr_t cur_word;
  lane_t       cur_lane;
  flash_word_u held_word;
  logic        held_valid;
  logic        discard;
  logic        hit;
  logic        tick_ok;
  logic        data_in;

  assign cur_word = pos[24:2];
  assign cur_lane = pos[1:0];
  // flash_address still names the word that was read last
  assign hit      = held_valid && (flash_address == cur_word);
  // Restart wins over a tick in the same cycle
  assign tick_ok  = (state == ST_IDLE) && sample_tick && play_ctrl.playing &&
                    !play_ctrl.restart;
  assign data_in  = (state == ST_WAIT) && flash_readdatavalid;

  always_comb
  begin
    if (play_ctrl.backward)
      next_pos = (pos == '0) ? LAST_POS : pos - 1'b1;
    else
      next_pos = (pos == LAST_POS) ? '0 : pos + 1'b1;
  end

  // ====================
  // Word store and sample select
  // ====================
  always_ff @(posedge CLK_50M)
  begin
    if (data_in)
    begin
      held_word.raw <= flash_readdata.raw;
      audio_sample  <= flash_readdata.lane[cur_lane];
    end
    else if (tick_ok && hit)
      audio_sample <= held_word.lane[cur_lane];
  end

  // ====================
  // Read FSM and position
  // ====================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state         <= ST_IDLE;
      pos           <= '0;
      flash_read    <= 1'b0;
      flash_address <= '0;
      held_valid    <= 1'b0;
      discard       <= 1'b0;
      sample_valid  <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      if (play_ctrl.restart)
      begin
        pos        <= play_ctrl.backward ? LAST_POS : '0;
        held_valid <= 1'b0;
      end
      case (state)
        ST_IDLE:
          if (tick_ok && hit)
          begin
            sample_valid <= 1'b1;
            pos          <= next_pos;
          end
          else if (tick_ok)
          begin
            flash_read    <= 1'b1;
            flash_address <= cur_word;
            held_valid    <= 1'b0;
            discard       <= 1'b0;
            state         <= ST_REQUEST;
          end
        ST_REQUEST:
        begin
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= ST_WAIT;
          end
          if (play_ctrl.restart)
            discard <= 1'b1;
        end
        ST_WAIT:
          if (flash_readdatavalid)
          begin
            state <= ST_IDLE;
            // Word fetched before a restart is thrown away
            if (!discard && !play_ctrl.restart)
            begin
              held_valid <= 1'b1;
              if (play_ctrl.playing)
              begin
                sample_valid <= 1'b1;
                pos          <= next_pos;
              end
            end
          end
          else if (play_ctrl.restart)
            discard <= 1'b1;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  a_addr_range: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    flash_address <= LAST_WORD)
    else $error("flash_address %h past last word", flash_address);

  a_read_hold: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address))
    else $error("read request dropped or moved under waitrequest");

endmodule

`default_nettype wire

// File: design/rate_control.sv
`timescale 1ns/1ps
`default_nettype none

module rate_control #(
  parameter player_pkg::div_count_t DEFAULT_DIV = 16'd2268,
  parameter player_pkg::div_count_t MIN_DIV     = 16'd568,
  parameter player_pkg::div_count_t MAX_DIV     = 16'd9072,
  parameter player_pkg::div_count_t DIV_STEP    = 16'd64
) (
  input  wire logic              CLK_50M,
  input  wire logic              arst_n,
  input  wire logic [2:0]        key_n,
  input  wire logic              playing,
  output player_pkg::div_count_t div_count,
  output logic                   sample_tick
);

  import player_pkg::*;

  // Lowest count that can still take a full step up in speed
  localparam logic [16:0] UP_LIMIT   = MIN_DIV + DIV_STEP;
  localparam div_count_t  DOWN_LIMIT = MAX_DIV - DIV_STEP;

  logic [2:0] key_meta;
  logic [2:0] key_sync;
  logic [2:0] key_prev;
  logic [2:0] key_press;
  div_count_t tick_cnt;

  // Key synchronizer and falling edge detect
  // bit 0 up, bit 1 down, bit 2 rate reset
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_meta  <= '1;
      key_sync  <= '1;
      key_prev  <= '1;
      key_press <= '0;
    end
    else
    begin
      key_meta  <= key_n;
      key_sync  <= key_meta;
      key_prev  <= key_sync;
      key_press <= key_prev & ~key_sync;
    end
  end

  // Divider count, clamped at both ends
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      div_count <= DEFAULT_DIV;
    else if (key_press[2])
      div_count <= DEFAULT_DIV;
    else if (key_press[0])
      div_count <= ({1'b0, div_count} >= UP_LIMIT) ? div_count - DIV_STEP : MIN_DIV;
    else if (key_press[1])
      div_count <= (div_count <= DOWN_LIMIT) ? div_count + DIV_STEP : MAX_DIV;
  end

  // Sample tick, one pulse per div_count cycles
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b0;
    end
    else if (!playing)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b0;
    end
    else if (tick_cnt >= div_count - 1'b1)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt    <= tick_cnt + 1'b1;
      sample_tick <= 1'b0;
    end
  end

  a_div_range: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (div_count >= MIN_DIV) && (div_count <= MAX_DIV))
    else $error("div_count %h outside its range", div_count);

endmodule

`default_nettype wire

// File: design/kbd_command.sv
`timescale 1ns/1ps
`default_nettype none

module kbd_command (
  input  wire logic                CLK_50M,
  input  wire logic                arst_n,
  input  wire player_pkg::sample_t kbd_ascii,
  input  wire logic                kbd_valid,
  output player_pkg::play_ctrl_t   play_ctrl
);

  import player_pkg::*;

  // Command decode, one code per strobe
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      play_ctrl <= '0;
    end
    else
    begin
      play_ctrl.restart <= 1'b0;
      if (kbd_valid)
      begin
        case (kbd_ascii)
          cmd_start:
            play_ctrl.playing <= 1'b1;
          cmd_stop:
            play_ctrl.playing <= 1'b0;
          // Direction change starts over from that end of the song
          cmd_forward:
          begin
            play_ctrl.backward <= 1'b0;
            play_ctrl.restart  <= 1'b1;
          end
          cmd_backward:
          begin
            play_ctrl.backward <= 1'b1;
            play_ctrl.restart  <= 1'b1;
          end
          cmd_restart:
            play_ctrl.restart <= 1'b1;
          default:
            ;
        endcase
      end
    end
  end

  // Keyboard strobes never come back to back
  a_restart_pulse: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    play_ctrl.restart |=> !play_ctrl.restart)
    else $error("restart held for more than one cycle");

endmodule

`default_nettype wire

// File: design/display_pkg.sv
`default_nettype none

package display_pkg;

  // Number of seven-segment digits on the board
  localparam int NUM_DIGITS = 6;

  // One hex digit to show
  typedef logic [3:0] hex_digit_t;

  // Segment pattern, active low, bit 0 is a, bit 6 is g
  typedef logic [6:0] seg_t;

  // All six digits, hex5 is the leftmost
  typedef struct packed {
    seg_t hex5;
    seg_t hex4;
    seg_t hex3;
    seg_t hex2;
    seg_t hex1;
    seg_t hex0;
  } seg_bank_t;

endpackage

`default_nettype wire

// File: design/player_pkg.sv
`default_nettype none

package player_pkg;

  // ====================
  // Audio and flash types
  // ====================

  // One signed audio sample
  typedef logic signed [7:0] sample_t;

  // Word address into the flash read port
  typedef logic [22:0] flash_addr_t;

  // Byte lane inside one flash word
  typedef logic [1:0] lane_t;

  // Clock cycles between sample ticks
  typedef logic [15:0] div_count_t;

  // One flash word, either as read data or as four samples
  // Lane 0 is the low byte
  typedef union packed {
    logic [31:0]       raw;
    sample_t [3:0]     lane;
  } flash_word_u;

  // Playback control from the keyboard
  typedef struct packed {
    logic playing;
    logic backward;
    logic restart;
  } play_ctrl_t;

  // ====================
  // Keyboard commands
  // ====================

  localparam logic [7:0] cmd_start    = 8'h45;
  localparam logic [7:0] cmd_stop     = 8'h44;
  localparam logic [7:0] cmd_forward  = 8'h46;
  localparam logic [7:0] cmd_backward = 8'h42;
  localparam logic [7:0] cmd_restart  = 8'h52;

endpackage

`default_nettype wire
